//--- alu_decode.sv
/* ALU instruction decoder */

`timescale 1ns/100ps

module alu_decode
    import alu_pkg::*;
(
    input  logic [INST_W-1:0] instr,
    output reg_addr_t         rs1_addr,
    output reg_addr_t         rs2_addr,
    output alu_cmd_t          cmd
);

    logic [OPCODE_W-1:0] opcode;
    logic [FUNCT3_W-1:0] funct3;
    logic                f7_b5;
    logic [IMM12_W-1:0]  imm12;

    ////////////////////////////////////////////////////////////
    // Instruction fields
    ////////////////////////////////////////////////////////////

    assign opcode   = instr[0 +: OPCODE_W];
    assign funct3   = instr[12 +: FUNCT3_W];
    assign f7_b5    = instr[30];
    assign imm12    = instr[20 +: IMM12_W];
    assign rs1_addr = instr[15 +: REG_ADDR_W];
    assign rs2_addr = instr[20 +: REG_ADDR_W];

    ////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////

    always_comb begin
        cmd.use_imm = (opcode == OPC_I_ARITH);
        cmd.imm     = {{(XLEN-IMM12_W){imm12[IMM12_W-1]}}, imm12};
        cmd.rd      = instr[7 +: REG_ADDR_W];
        cmd.op      = OP_NONE;

        if (opcode == OPC_I_ARITH) begin
            // No SUBI, shift amount sits in imm[4:0]
            case (funct3)
                F3_ADD_SUB: cmd.op = OP_ADD;
                F3_SLL:     cmd.op = OP_SLL;
                F3_SLT:     cmd.op = OP_SLT;
                F3_SLTU:    cmd.op = OP_SLTU;
                F3_XOR:     cmd.op = OP_XOR;
                F3_SR:      cmd.op = f7_b5 ? OP_SRA : OP_SRL;
                F3_OR:      cmd.op = OP_OR;
                F3_AND:     cmd.op = OP_AND;
                default:    cmd.op = OP_NONE;
            endcase
        end else if (opcode == OPC_R_ARITH) begin
            case (funct3)
                F3_ADD_SUB: cmd.op = f7_b5 ? OP_SUB : OP_ADD;
                F3_SLL:     cmd.op = OP_SLL;
                F3_SLT:     cmd.op = OP_SLT;
                F3_SLTU:    cmd.op = OP_SLTU;
                F3_XOR:     cmd.op = OP_XOR;
                F3_SR:      cmd.op = f7_b5 ? OP_SRA : OP_SRL;
                F3_OR:      cmd.op = OP_OR;
                F3_AND:     cmd.op = OP_AND;
                default:    cmd.op = OP_NONE;
            endcase
        end
    end

endmodule

//--- alu_execute.sv
/* ALU datapath */

`timescale 1ns/100ps

module alu_execute
    import alu_pkg::*;
(
    input  alu_cmd_t cmd,
    input  xlen_t    rs1_val,
    input  xlen_t    rs2_val,
    output xlen_t    result
);

    xlen_t op_b;
    xlen_t shift_res;
    logic  lt_signed;
    logic  lt_unsigned;

    ////////////////////////////////////////////////////////////
    // Operands
    ////////////////////////////////////////////////////////////

    assign op_b = cmd.use_imm ? cmd.imm : rs2_val;

    // SLTIU compares against the sign-extended immediate as unsigned
    assign lt_signed   = $signed(rs1_val) < $signed(op_b);
    assign lt_unsigned = rs1_val < op_b;

    // Only the low bits of rs2 or the immediate set the shift amount
    alu_shift i_shift (
        .value  (rs1_val),
        .amount (op_b[SHAMT_W-1:0]),
        .op     (cmd.op),
        .result (shift_res)
    );

    ////////////////////////////////////////////////////////////
    // Result mux
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (cmd.op)
            OP_ADD:  result = rs1_val + op_b;
            OP_SUB:  result = rs1_val - op_b;
            OP_SLT:  result = {{(XLEN-1){1'b0}}, lt_signed};
            OP_SLTU: result = {{(XLEN-1){1'b0}}, lt_unsigned};
            OP_XOR:  result = rs1_val ^ op_b;
            OP_OR:   result = rs1_val | op_b;
            OP_AND:  result = rs1_val & op_b;
            OP_SLL,
            OP_SRL,
            OP_SRA:  result = shift_res;
            // Unknown encodings still write, with zero
            default: result = '0;
        endcase
    end

endmodule

//--- alu_pkg.sv
/* RV32I integer ALU shared definitions */

package alu_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = $clog2(XLEN);
    localparam int IMM12_W    = 12;
    localparam int INST_W     = 32;
    localparam int OPCODE_W   = 7;
    localparam int FUNCT3_W   = 3;

    ////////////////////////////////////////////////////////////
    // Instruction codes
    ////////////////////////////////////////////////////////////

    // Major opcodes handled by this unit
    localparam logic [OPCODE_W-1:0] OPC_I_ARITH = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OPC_R_ARITH = 7'b0110011;

    // funct3, shared by register and immediate forms
    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SR      = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    typedef enum logic [3:0] {
        OP_NONE = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_SLT  = 4'd3,
        OP_SLTU = 4'd4,
        OP_XOR  = 4'd5,
        OP_OR   = 4'd6,
        OP_AND  = 4'd7,
        OP_SLL  = 4'd8,
        OP_SRL  = 4'd9,
        OP_SRA  = 4'd10
    } alu_op_e;

    // Decoded command, immediate already sign-extended
    typedef struct packed {
        alu_op_e   op;
        logic      use_imm;
        xlen_t     imm;
        reg_addr_t rd;
    } alu_cmd_t;

    // Destination register write
    typedef struct packed {
        logic      wr;
        reg_addr_t addr;
        xlen_t     val;
    } rd_write_t;

endpackage

//--- alu_result.sv
/* Writeback register */

`timescale 1ns/100ps

module alu_result
    import alu_pkg::*;
(
    input  logic      aclk,
    input  logic      rst_n,
    input  logic      valid,
    input  reg_addr_t rd_addr,
    input  xlen_t     value,
    output rd_write_t rd
);

    // Address and value hold when idle, only the strobe drops
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            rd <= '0;
        end else begin
            rd.wr <= valid;
            if (valid) begin
                rd.addr <= rd_addr;
                rd.val  <= value;
            end
        end
    end

endmodule

//--- alu_shift.sv
/* Barrel shifter */

`timescale 1ns/100ps

module alu_shift
    import alu_pkg::*;
(
    input  xlen_t              value,
    input  logic [SHAMT_W-1:0] amount,
    input  alu_op_e            op,
    output xlen_t              result
);

    xlen_t value_rev;
    xlen_t stage [SHAMT_W+1];
    xlen_t stage_rev;
    logic  fill;

    assign fill = (op == OP_SRA) && value[XLEN-1];

    // Left shift runs through the right shifter on the bit-reversed word
    always_comb begin
        for (int i = 0; i < XLEN; i++) begin
            value_rev[i] = value[XLEN-1-i];
        end
        stage[0] = (op == OP_SLL) ? value_rev : value;

        // One stage per amount bit with the distance doubling
        for (int s = 0; s < SHAMT_W; s++) begin
            stage[s+1] = amount[s] ? ((stage[s] >> (2**s)) | ({XLEN{fill}} << (XLEN - 2**s)))
                                   : stage[s];
        end

        for (int i = 0; i < XLEN; i++) begin
            stage_rev[i] = stage[SHAMT_W][XLEN-1-i];
        end
    end

    assign result = (op == OP_SLL) ? stage_rev : stage[SHAMT_W];

endmodule

//--- alu_top.sv
/* RV32I integer ALU */

`timescale 1ns/100ps

module alu_top
    import alu_pkg::*;
(
    input  logic              aclk,
    input  logic              rst_n,
    // Instruction input
    input  logic              alu_valid,
    input  logic [INST_W-1:0] alu_instbus,
    // Register file read, same cycle
    output reg_addr_t         alu_rs1_addr,
    output reg_addr_t         alu_rs2_addr,
    input  xlen_t             alu_rs1_val,
    input  xlen_t             alu_rs2_val,
    // Destination write, one cycle later
    output rd_write_t         alu_rd
);

    alu_cmd_t cmd;
    xlen_t    result;

    ////////////////////////////////////////////////////////////
    // Decode and execute, combinational
    ////////////////////////////////////////////////////////////

    alu_decode i_decode (
        .instr    (alu_instbus),
        .rs1_addr (alu_rs1_addr),
        .rs2_addr (alu_rs2_addr),
        .cmd      (cmd)
    );

    alu_execute i_execute (
        .cmd     (cmd),
        .rs1_val (alu_rs1_val),
        .rs2_val (alu_rs2_val),
        .result  (result)
    );

    ////////////////////////////////////////////////////////////
    // Writeback
    ////////////////////////////////////////////////////////////

    alu_result i_result (
        .aclk    (aclk),
        .rst_n   (rst_n),
        .valid   (alu_valid),
        .rd_addr (cmd.rd),
        .value   (result),
        .rd      (alu_rd)
    );

endmodule

//--- files.f
+incdir+.
alu_pkg.sv
alu_shift.sv
alu_decode.sv
alu_execute.sv
alu_result.sv
alu_top.sv
tb_alu.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_alu -o tb_alu_sim \
    >"$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see $BUILD_LOG"
    exit 1
fi

./obj_dir/tb_alu_sim >"$SIM_LOG" 2>&1
if [ $? -ne 0 ]; then
    echo "Simulation returned an error, see $SIM_LOG"
    exit 1
fi

if grep -q "Checks failed" "$SIM_LOG"; then
    echo "FAIL, see $SIM_LOG"
    exit 1
fi

echo "PASS"
exit 0

//--- tb_alu_model.svh
/* ALU testbench model and encoders */

`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// RV32I major opcodes for OP-IMM and OP
localparam logic [6:0] OPC_IMM = 7'b0010011;
localparam logic [6:0] OPC_REG = 7'b0110011;

logic [31:0] rng_state = 32'hc04d;

// Linear congruential generator
function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
endfunction

function automatic logic [31:0] encode_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {funct7, rs2, rs1, f3, rd, OPC_REG};
endfunction

function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, OPC_IMM};
endfunction

function automatic logic [31:0] encode_shift_imm(input logic arith, input logic [4:0] shamt,
                                                 input logic [4:0] rs1, input logic [2:0] f3,
                                                 input logic [4:0] rd);
    return encode_i({1'b0, arith, 5'd0, shamt}, rs1, f3, rd);
endfunction

// Expected rd value per the RV32I arithmetic rules
function automatic logic [31:0] ref_result(input logic [31:0] instr, input logic [31:0] a,
                                           input logic [31:0] b);
    logic [6:0]  opcode;
    logic [2:0]  f3;
    logic [31:0] op_b;
    logic [4:0]  sh;
    logic [31:0] res;
    opcode = instr[6:0];
    f3     = instr[14:12];
    if (opcode == OPC_IMM) begin
        op_b = {{20{instr[31]}}, instr[31:20]};
    end else if (opcode == OPC_REG) begin
        op_b = b;
    end else begin
        return 32'd0;
    end
    sh = op_b[4:0];
    case (f3)
        3'd0: res = (opcode == OPC_REG && instr[30]) ? a - op_b : a + op_b;
        3'd1: res = a << sh;
        3'd2: res = {31'd0, $signed(a) < $signed(op_b)};
        3'd3: res = {31'd0, a < op_b};
        3'd4: res = a ^ op_b;
        3'd5: begin
            if (instr[30]) begin
                res = $signed(a) >>> sh;
            end else begin
                res = a >> sh;
            end
        end
        3'd6: res = a | op_b;
        default: res = a & op_b;
    endcase
    return res;
endfunction

// Mixed legal and unknown encodings for the stream test
function automatic logic [31:0] random_instr(input logic [4:0] rd);
    logic [31:0] r;
    logic [31:0] instr;
    logic [2:0]  f3;
    logic [6:0]  funct7;
    logic [6:0]  opcode;
    r      = next_rand();
    f3     = r[4:2];
    funct7 = (r[5] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
    case (r[1:0])
        2'd0: instr = encode_r(funct7, r[10:6], r[15:11], f3, rd);
        2'd1: instr = encode_shift_imm(r[5] && r[16], r[10:6], r[15:11],
                                       r[16] ? 3'd5 : 3'd1, rd);
        2'd2: instr = encode_i(r[31:20], r[15:11], (f3 == 3'd1 || f3 == 3'd5) ? 3'd6 : f3, rd);
        default: begin
            opcode = r[22:16];
            if (opcode == OPC_IMM || opcode == OPC_REG) begin
                opcode = 7'h0b;
            end
            instr      = encode_r(funct7, r[10:6], r[15:11], f3, rd);
            instr[6:0] = opcode;
        end
    endcase
    return instr;
endfunction

`endif

//--- tb_alu.sv
/* RV32I ALU testbench */

`timescale 1ns/100ps

module tb_alu
    import alu_pkg::*;
();

    localparam int DRAIN_TIMEOUT = 20;
    localparam int STREAM_LEN    = 200;

    logic              aclk = 1'b0;
    logic              rst_n;
    logic              alu_valid;
    logic [INST_W-1:0] alu_instbus;
    reg_addr_t         alu_rs1_addr;
    reg_addr_t         alu_rs2_addr;
    xlen_t             alu_rs1_val;
    xlen_t             alu_rs2_val;
    rd_write_t         alu_rd;

    rd_write_t exp_q;
    logic      armed;
    logic      timed_out;
    int        errors;
    int        n_valid;
    int        n_writes;

    `include "tb_alu_model.svh"

    alu_top i_dut (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .alu_valid    (alu_valid),
        .alu_instbus  (alu_instbus),
        .alu_rs1_addr (alu_rs1_addr),
        .alu_rs2_addr (alu_rs2_addr),
        .alu_rs1_val  (alu_rs1_val),
        .alu_rs2_val  (alu_rs2_val),
        .alu_rd       (alu_rd)
    );

    always #5 aclk = ~aclk;

    ////////////////////////////////////////////////////////////
    // Expected writeback, one cycle behind the inputs
    ////////////////////////////////////////////////////////////

    always @(posedge aclk) begin
        armed <= 1'b1;
        if (!rst_n) begin
            exp_q <= '0;
        end else begin
            exp_q.wr <= alu_valid;
            if (alu_valid) begin
                exp_q.addr <= alu_instbus[11:7];
                exp_q.val  <= ref_result(alu_instbus, alu_rs1_val, alu_rs2_val);
            end
        end
    end

    always @(negedge aclk) begin
        if (alu_rd.wr === 1'b1) begin
            n_writes = n_writes + 1;
        end
    end

    wr_check: assert property (@(posedge aclk) armed |-> (alu_rd.wr == exp_q.wr))
        else begin
            errors = errors + 1;
            $display("ERROR alu_rd.wr expected %h actual %h",
                     $sampled(exp_q.wr), $sampled(alu_rd.wr));
        end

    addr_check: assert property (@(posedge aclk) armed |-> (alu_rd.addr == exp_q.addr))
        else begin
            errors = errors + 1;
            $display("ERROR alu_rd.addr expected %h actual %h",
                     $sampled(exp_q.addr), $sampled(alu_rd.addr));
        end

    val_check: assert property (@(posedge aclk) armed |-> (alu_rd.val == exp_q.val))
        else begin
            errors = errors + 1;
            $display("ERROR alu_rd.val expected %h actual %h",
                     $sampled(exp_q.val), $sampled(alu_rd.val));
        end

    // Source addresses are plain instruction fields
    rs1_check: assert property (@(posedge aclk) armed |-> (alu_rs1_addr == alu_instbus[19:15]))
        else begin
            errors = errors + 1;
            $display("ERROR alu_rs1_addr expected %h actual %h",
                     $sampled(alu_instbus[19:15]), $sampled(alu_rs1_addr));
        end

    rs2_check: assert property (@(posedge aclk) armed |-> (alu_rs2_addr == alu_instbus[24:20]))
        else begin
            errors = errors + 1;
            $display("ERROR alu_rs2_addr expected %h actual %h",
                     $sampled(alu_instbus[24:20]), $sampled(alu_rs2_addr));
        end

    ////////////////////////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////////////////////////

    task automatic issue(input logic [31:0] instr, input xlen_t a, input xlen_t b);
        @(negedge aclk);
        alu_valid   = 1'b1;
        alu_instbus = instr;
        alu_rs1_val = a;
        alu_rs2_val = b;
        n_valid     = n_valid + 1;
    endtask

    // Idle cycles still carry random words on the bus
    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(negedge aclk);
            alu_valid   = 1'b0;
            alu_instbus = next_rand();
            alu_rs1_val = next_rand();
            alu_rs2_val = next_rand();
        end
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        idle(1);
        while (n_writes != n_valid && cycles < DRAIN_TIMEOUT) begin
            @(posedge aclk);
            cycles = cycles + 1;
        end
        if (n_writes != n_valid) begin
            timed_out = 1'b1;
            errors    = errors + 1;
            $display("Timeout: only %0d writes seen for %0d instructions", n_writes, n_valid);
        end
    endtask

    task automatic run_register_ops();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  funct7;
        for (int i = 0; i < 40; i++) begin
            r      = next_rand();
            f3     = r[2:0];
            funct7 = (r[3] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
            issue(encode_r(funct7, r[8:4], r[13:9], f3, r[18:14]), next_rand(), next_rand());
        end
        // Opposite signs, signed and unsigned order disagree
        issue(encode_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd3), 32'hffff_fff0, 32'h0000_0010);
        issue(encode_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd4), 32'hffff_fff0, 32'h0000_0010);
        issue(encode_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd5), 32'h0000_0010, 32'hffff_fff0);
        issue(encode_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd6), 32'h0000_0010, 32'hffff_fff0);
        issue(encode_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd7), 32'h7fff_ffff, 32'h0000_0001);
        issue(encode_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd8), 32'h0000_0000, 32'h0000_0001);
        idle(2);
    endtask

    task automatic run_immediate_ops();
        logic [31:0] r;
        logic [2:0]  f3;
        for (int i = 0; i < 40; i++) begin
            r = next_rand();
            case (r[2:0])
                3'd1:    f3 = 3'd0;
                3'd5:    f3 = 3'd7;
                default: f3 = r[2:0];
            endcase
            issue(encode_i(r[31:20], r[8:4], f3, r[13:9]), next_rand(), next_rand());
        end
        // SLTIU against -1 extends to all ones
        issue(encode_i(12'hfff, 5'd1, 3'd3, 5'd9), 32'h0000_0005, next_rand());
        issue(encode_i(12'hfff, 5'd1, 3'd3, 5'd10), 32'hffff_ffff, next_rand());
        issue(encode_i(12'hfff, 5'd1, 3'd3, 5'd11), 32'hffff_fffe, next_rand());
        issue(encode_i(12'h800, 5'd1, 3'd2, 5'd12), 32'hffff_ffff, next_rand());
        issue(encode_i(12'h800, 5'd1, 3'd0, 5'd13), 32'h0000_0000, next_rand());
        idle(2);
    endtask

    task automatic run_shifts();
        logic [31:0] r;
        logic [31:0] a;
        logic [4:0]  amt;
        for (int k = 0; k < 12; k++) begin
            r = next_rand();
            a = next_rand();
            case (k % 4)
                0:       amt = 5'd0;
                1:       amt = 5'd1;
                2:       amt = 5'd31;
                default: amt = r[4:0];
            endcase
            if (k < 8) begin
                a[31] = 1'b1;
            end
            // Upper bits of rs2 must not affect the amount
            issue(encode_r(7'h00, 5'd2, 5'd1, 3'd1, 5'd14), a, {r[31:5], amt});
            issue(encode_r(7'h00, 5'd2, 5'd1, 3'd5, 5'd15), a, {r[31:5], amt});
            issue(encode_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd16), a, {r[31:5], amt});
            issue(encode_shift_imm(1'b0, amt, 5'd1, 3'd1, 5'd17), a, r);
            issue(encode_shift_imm(1'b0, amt, 5'd1, 3'd5, 5'd18), a, r);
            issue(encode_shift_imm(1'b1, amt, 5'd1, 3'd5, 5'd19), a, r);
        end
        idle(2);
    endtask

    task automatic run_unknown_encodings();
        logic [6:0]  bad_ops [8] = '{7'h37, 7'h17, 7'h03, 7'h23, 7'h63, 7'h6f, 7'h7f, 7'h00};
        logic [31:0] instr;
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            r     = next_rand();
            instr = encode_r(r[31:25], r[24:20], r[19:15], r[14:12], r[11:7]);
            if (i < 8) begin
                instr[6:0] = bad_ops[i];
            end else if (r[6:0] == OPC_IMM || r[6:0] == OPC_REG) begin
                instr[6:0] = 7'h5b;
            end else begin
                instr[6:0] = r[6:0];
            end
            issue(instr, next_rand(), next_rand());
        end
        // Only funct7 bit 5 is decoded, other bits are ignored
        issue(encode_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd20), 32'h8000_1234, 32'h0000_0004);
        issue(encode_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd21), 32'h0000_0003, 32'h0000_0004);
        issue(encode_r(7'h40, 5'd2, 5'd1, 3'd0, 5'd22), 32'h0000_0003, 32'h0000_0004);
        idle(2);
    endtask

    task automatic run_stream();
        logic [31:0] r;
        for (int i = 0; i < STREAM_LEN; i++) begin
            issue(random_instr(reg_addr_t'(i)), next_rand(), next_rand());
            r = next_rand();
            if (r[3:0] == 4'd0) begin
                idle(1 + int'(r[5:4]));
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst_n       = 1'b0;
        alu_valid   = 1'b0;
        alu_instbus = '0;
        alu_rs1_val = '0;
        alu_rs2_val = '0;
        armed       = 1'b0;
        timed_out   = 1'b0;
        errors      = 0;
        n_valid     = 0;
        n_writes    = 0;

        repeat (3) @(posedge aclk);
        @(negedge aclk);
        rst_n = 1'b1;
        idle(4);

        run_register_ops();
        run_immediate_ops();
        run_shifts();
        run_unknown_encodings();
        run_stream();
        wait_for_drain();

        // No late writes after the stream
        idle(3);
        @(posedge aclk);
        if (!timed_out && n_writes != n_valid) begin
            errors = errors + 1;
            $display("Write count mismatch: %0d writes for %0d instructions", n_writes, n_valid);
        end

        $display("Summary: %0d instructions, %0d writes, %0d errors", n_valid, n_writes, errors);
        if (errors == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
